/* logic/link_pkg.sv */
// link package
// frame format, data word and scheduling constants shared by the
// pattern link blocks

package link_pkg;

	// data bits carried in one frame
	localparam int WORD_BITS = 10;
	// start bit, data bits and stop bit
	localparam int FRAME_BITS = WORD_BITS + 2;

	// top bit of the word-period counter
	localparam int PICKOFF = 4;
	// clocks between launches, one full wrap of the slot counter
	localparam int WORD_PERIOD = 2 ** (PICKOFF + 1);

	// clocks that link_ready stays low once reset is released
	localparam int RESET_HOLD = 64;

	// one data word as sent in a frame, bit 0 goes out first
	typedef logic [WORD_BITS-1:0] link_word_t;

	// word-period slot counter
	typedef logic [PICKOFF:0] slot_t;

	// bit position within a frame, serializer and deserializer
	typedef logic [$clog2(FRAME_BITS)-1:0] bit_index_t;

	// clocks counted during the reset hold
	typedef logic [$clog2(RESET_HOLD)-1:0] hold_count_t;

	// receiver FSM
	typedef enum logic [1:0] {hunt, data, stop} rx_state_t;

endpackage

/* logic/prbs_pkg.sv */
// PRBS package
// order, feedback taps, start state and state type of the
// PRBS-15 test pattern

package prbs_pkg;

	// pattern order, also the state length
	localparam int PRBS_ORDER = 15;

	// each new bit is the xor of the bits this many places earlier
	localparam int PRBS_TAP_A = 15;
	localparam int PRBS_TAP_B = 14;

	// last PRBS_ORDER bits of the stream
	// bit 0 holds the newest bit, bit PRBS_ORDER-1 the oldest
	typedef logic [PRBS_ORDER-1:0] prbs_state_t;

	// any nonzero value works as a start state
	// the all-zero state would lock the pattern
	localparam prbs_state_t PRBS_SEED = 15'h2f5a;

endpackage

/* logic/power_on_reset.sv */
// power-on reset stretcher
// keeps link_ready low during reset and for a fixed hold after it

`timescale 1ns/100ps

module power_on_reset import link_pkg::*; (
	input  logic clock,
	input  logic reset,
	output logic link_ready
);

	// clocks since reset was released
	hold_count_t hold_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_count <= '0;
			link_ready <= 1'b0;
		end else if (!link_ready) begin
			hold_count <= hold_count + 1'b1;
			// last clock of the hold, ready from the next clock on
			if (hold_count == hold_count_t'(RESET_HOLD - 1)) begin
				link_ready <= 1'b1;
			end
		end
	end

	// once up, the link only drops when reset is applied
	link_ready_stays_up: assert property (
		@(posedge clock) $fell(link_ready) |-> $past(reset)
	) else $error("link_ready fell without reset");

endmodule

/* logic/prbs_generator.sv */
// parallel PRBS-15 generator
// advances the pattern ten bits per request and presents the
// ten most recent bits with the oldest in bit 0

`timescale 1ns/100ps

module prbs_generator import link_pkg::*, prbs_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       prbs_advance,
	output link_word_t pattern_word
);

	// stream history, state[0] is the newest bit
	prbs_state_t state;
	// history after ten more steps of the recurrence
	prbs_state_t stepped;

	// ten recurrence steps unrolled into one clock
	always_comb begin
		stepped = state;
		for (int step = 0; step < WORD_BITS; step++) begin
			// new bit from the bits 15 and 14 places back
			stepped = {stepped[PRBS_ORDER-2:0],
				stepped[PRBS_TAP_A-1] ^ stepped[PRBS_TAP_B-1]};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= PRBS_SEED;
		end else if (prbs_advance) begin
			state <= stepped;
		end
	end

	// word is the newest ten bits in stream order
	// the seed window itself forms the first word
	always_comb begin
		for (int bit_pos = 0; bit_pos < WORD_BITS; bit_pos++) begin
			pattern_word[bit_pos] = state[WORD_BITS-1-bit_pos];
		end
	end

	// checks apply once link reset has cleanly released
	// an all-zero state would freeze the pattern at zero
	state_never_zero: assert property (
		@(posedge clock) disable iff (reset !== 1'b0)
		state != '0
	) else $error("PRBS state reached all zero");

endmodule

/* logic/word_scheduler.sv */
// word scheduler
// free-running word-period counter, buffers one pattern word at
// slot 0 and launches it at slot 1 while data_enable is high

`timescale 1ns/100ps

module word_scheduler import link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       data_enable,
	input  link_word_t pattern_word,
	output logic       prbs_advance,
	output logic       word_strobe,
	output link_word_t tx_word
);

	// position within the word period, wraps every WORD_PERIOD clocks
	slot_t slot;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot <= '0;
			prbs_advance <= 1'b0;
			word_strobe <= 1'b0;
		end else begin
			// counter keeps running even while data_enable is low
			slot <= slot + 1'b1;

			// slot 0 takes the current word and asks for the next one
			prbs_advance <= (slot == '0) && data_enable;
			if ((slot == '0) && data_enable) begin
				tx_word <= pattern_word;
			end

			// slot 1 launches only a word buffered in this period
			// prbs_advance is high exactly then
			word_strobe <= (slot == slot_t'(1)) && prbs_advance;
		end
	end

	// generator steps on the clock before launch, so tx_word already
	// holds the old word when pattern_word moves on
	advance_then_strobe: assert property (
		@(posedge clock) disable iff (reset !== 1'b0)
		prbs_advance |=> word_strobe
	) else $error("advance not followed by word_strobe");

endmodule

/* logic/frame_serializer.sv */
// frame serializer
// sends a start bit of 1, ten data bits lsb first and a stop bit of 0
// on complementary serial_p and serial_n lines, idles low

`timescale 1ns/100ps

module frame_serializer import link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       word_strobe,
	input  link_word_t tx_word,
	output logic       tx_busy,
	output logic       serial_p,
	output logic       serial_n
);

	// frame bits, bit 0 is on the line
	logic [FRAME_BITS-1:0] frame_shift;
	logic [FRAME_BITS-1:0] frame_next;
	// clocks left in the frame after the current one
	bit_index_t bit_count;

	always_comb begin
		if (word_strobe) begin
			// stop, data, start from msb to lsb
			frame_next = {1'b0, tx_word, 1'b1};
		end else if (tx_busy) begin
			// zeros shifted in leave the line low after the stop bit
			frame_next = {1'b0, frame_shift[FRAME_BITS-1:1]};
		end else begin
			frame_next = frame_shift;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			frame_shift <= '0;
			serial_p <= 1'b0;
			serial_n <= 1'b1;
			tx_busy <= 1'b0;
			bit_count <= '0;
		end else begin
			frame_shift <= frame_next;
			// matched flop pair drives both lines on the same edge
			serial_p <= frame_next[0];
			serial_n <= ~frame_next[0];
			if (word_strobe) begin
				tx_busy <= 1'b1;
				bit_count <= bit_index_t'(FRAME_BITS - 1);
			end else if (tx_busy) begin
				if (bit_count == '0) begin
					tx_busy <= 1'b0;
				end else begin
					bit_count <= bit_count - 1'b1;
				end
			end
		end
	end

	// lines stay complementary outside reset
	lines_complementary: assert property (
		@(posedge clock) disable iff (reset !== 1'b0)
		serial_n == !serial_p
	) else $error("serial_n is not the inverse of serial_p");

	// scheduler spacing must leave room for a whole frame
	no_strobe_while_busy: assert property (
		@(posedge clock) disable iff (reset !== 1'b0)
		word_strobe |-> !tx_busy
	) else $error("word_strobe while a frame is in flight");

endmodule

/* logic/frame_deserializer.sv */
// frame deserializer
// hunts for a start bit, collects ten data bits lsb first and checks
// the stop bit, reports the word or a frame error

`timescale 1ns/100ps

module frame_deserializer import link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       serial_in,
	output link_word_t rx_word,
	output logic       rx_valid,
	output logic       rx_frame_error
);

	rx_state_t state;
	// data bits taken so far in this frame
	bit_index_t bit_count;
	// incoming bits enter at the top and move down to bit 0
	link_word_t shift_word;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= hunt;
			bit_count <= '0;
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end else begin
			// report strobes last one clock
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;
			unique case (state)
				hunt: begin
					bit_count <= '0;
					// idle line is low, first 1 is a start bit
					if (serial_in) begin
						state <= data;
					end
				end
				data: begin
					shift_word <= {serial_in, shift_word[WORD_BITS-1:1]};
					bit_count <= bit_count + 1'b1;
					// tenth data bit, stop bit comes next
					if (bit_count == bit_index_t'(WORD_BITS - 1)) begin
						state <= stop;
					end
				end
				stop: begin
					state <= hunt;
					if (serial_in) begin
						// broken stop bit, word dropped
						rx_frame_error <= 1'b1;
					end else begin
						rx_valid <= 1'b1;
						rx_word <= shift_word;
					end
				end
				default: begin
					state <= hunt;
				end
			endcase
		end
	end

	// a frame is either good or bad, never both
	one_report_per_frame: assert property (
		@(posedge clock) disable iff (reset !== 1'b0)
		!(rx_valid && rx_frame_error)
	) else $error("rx_valid and rx_frame_error together");

endmodule

/* logic/serdes_link_top.sv */
// serial test-pattern link top
// reset stretcher, PRBS source, word scheduler, frame serializer
// and loopback frame deserializer on one clock

`timescale 1ns/100ps

module serdes_link_top import link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       data_enable,
	input  logic       serial_in,
	output logic       link_ready,
	output logic       serial_p,
	output logic       serial_n,
	output logic       tx_busy,
	output link_word_t rx_word,
	output logic       rx_valid,
	output logic       rx_frame_error
);

	// everything past the stretcher stays in reset until link_ready
	logic       link_reset;
	logic       prbs_advance;
	logic       word_strobe;
	link_word_t pattern_word;
	link_word_t tx_word;

	assign link_reset = ~link_ready;

	power_on_reset u_power_on_reset (
		.clock(clock),
		.reset(reset),
		.link_ready(link_ready)
	);

	prbs_generator u_prbs_generator (
		.clock(clock),
		.reset(link_reset),
		.prbs_advance(prbs_advance),
		.pattern_word(pattern_word)
	);

	word_scheduler u_word_scheduler (
		.clock(clock),
		.reset(link_reset),
		.data_enable(data_enable),
		.pattern_word(pattern_word),
		.prbs_advance(prbs_advance),
		.word_strobe(word_strobe),
		.tx_word(tx_word)
	);

	frame_serializer u_frame_serializer (
		.clock(clock),
		.reset(link_reset),
		.word_strobe(word_strobe),
		.tx_word(tx_word),
		.tx_busy(tx_busy),
		.serial_p(serial_p),
		.serial_n(serial_n)
	);

	// receive side, serial_in is looped back outside the chip
	frame_deserializer u_frame_deserializer (
		.clock(clock),
		.reset(link_reset),
		.serial_in(serial_in),
		.rx_word(rx_word),
		.rx_valid(rx_valid),
		.rx_frame_error(rx_frame_error)
	);

endmodule

/* test/serdes_link_checks.sv */
// loopback link checker
// reference model for reset hold, frame timing and the PRBS-15
// recurrence, with assertions on the link top ports

`timescale 1ns/100ps

module serdes_link_checks import link_pkg::*, prbs_pkg::*; (
	input logic       clock,
	input logic       reset,
	input logic       data_enable,
	input logic       serial_in,
	input logic       link_ready,
	input logic       serial_p,
	input logic       serial_n,
	input logic       tx_busy,
	input link_word_t rx_word,
	input logic       rx_valid,
	input logic       rx_frame_error
);

	// clocks since reset was released
	int since_reset;
	// clocks with tx_busy high so far in this frame
	int busy_run;
	// clocks since the last frame start
	int since_rise;
	// received bits the history can vouch for
	int bits_seen;
	// assertion failures so far
	int error_count;
	logic busy_prev;
	logic busy_rise;
	// data_enable was low at some clock since the last frame start
	logic enable_dropped;
	// serial_in level at the stop bit sample
	logic stop_high;
	// data bits as they left on serial_p
	link_word_t tx_bits;
	// received stream, bit k is the bit k+1 places back
	logic [PRBS_TAP_A-1:0] stream_hist;
	link_word_t predicted;
	link_word_t predict_mask;

	assign busy_rise = tx_busy && !busy_prev;

	// next word from the recurrence, masked where the history is short
	always_comb begin
		for (int i = 0; i < WORD_BITS; i++) begin
			predicted[i] = stream_hist[PRBS_TAP_A-1-i] ^ stream_hist[PRBS_TAP_B-1-i];
			predict_mask[i] = (bits_seen + i >= PRBS_TAP_A);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			since_reset <= 0;
			busy_run <= 0;
			since_rise <= 0;
			bits_seen <= 0;
			busy_prev <= 1'b0;
			enable_dropped <= 1'b1;
			stop_high <= 1'b0;
		end else begin
			since_reset <= since_reset + 1;
			busy_prev <= tx_busy;
			busy_run <= tx_busy ? busy_run + 1 : 0;
			since_rise <= busy_rise ? 1 : since_rise + 1;
			enable_dropped <= busy_rise ? !data_enable : (enable_dropped || !data_enable);
			if (tx_busy && busy_run >= 1 && busy_run <= WORD_BITS) begin
				tx_bits[busy_run-1] <= serial_p;
			end
			if (tx_busy && busy_run == FRAME_BITS - 1) begin
				stop_high <= serial_in;
			end
			if (rx_valid) begin
				// newest bit lands in bit 0
				for (int k = 0; k < WORD_BITS; k++) begin
					stream_hist[k] <= rx_word[WORD_BITS-1-k];
				end
				for (int k = WORD_BITS; k < PRBS_TAP_A; k++) begin
					stream_hist[k] <= stream_hist[k-WORD_BITS];
				end
				bits_seen <= bits_seen + WORD_BITS;
			end
			// a dropped word breaks the stream, history starts over
			if (rx_frame_error) begin
				bits_seen <= 0;
			end
		end
	end

	hold_length: assert property (@(posedge clock) disable iff (reset)
		link_ready == (since_reset >= RESET_HOLD))
		else begin
			$error("FAILED reset hold: expected %0h, actual %0h",
				$sampled(since_reset >= RESET_HOLD), $sampled(link_ready));
			error_count++;
		end
	quiet_during_hold: assert property (@(posedge clock) disable iff (reset)
		!link_ready |-> !serial_p && serial_n && !tx_busy && !rx_valid)
		else begin
			$error("link active before link_ready");
			error_count++;
		end
	lines_inverse: assert property (@(posedge clock) disable iff (reset)
		serial_n == !serial_p)
		else begin
			$error("FAILED serial_n: expected %0h, actual %0h",
				!$sampled(serial_p), $sampled(serial_n));
			error_count++;
		end
	// first busy clock carries the start bit, last one the stop bit
	start_stop_bits: assert property (@(posedge clock) disable iff (reset)
		tx_busy && (busy_run == 0 || busy_run == FRAME_BITS - 1) |-> serial_p == (busy_run == 0))
		else begin
			$error("FAILED frame start and stop bits: expected %0h, actual %0h",
				$sampled(busy_run == 0), $sampled(serial_p));
			error_count++;
		end
	busy_length: assert property (@(posedge clock) disable iff (reset)
		busy_prev && !tx_busy |-> busy_run == FRAME_BITS)
		else begin
			$error("FAILED tx_busy length: expected %0d, actual %0d",
				FRAME_BITS, $sampled(busy_run));
			error_count++;
		end
	launch_spacing: assert property (@(posedge clock) disable iff (reset)
		busy_rise && !enable_dropped |-> since_rise == WORD_PERIOD)
		else begin
			$error("FAILED launch spacing: expected %0d, actual %0d",
				WORD_PERIOD, $sampled(since_rise));
			error_count++;
		end
	// slot 0 sample sits three clocks before busy_rise is seen
	no_launch_disabled: assert property (@(posedge clock) disable iff (reset)
		busy_rise |-> $past(data_enable, 3))
		else begin
			$error("frame started while data_enable was low");
			error_count++;
		end
	// clocks counted from word_strobe, one before the tx_busy rise
	loopback_latency: assert property (@(posedge clock) disable iff (reset)
		rx_valid || rx_frame_error |-> since_rise == FRAME_BITS)
		else begin
			$error("FAILED loopback latency: expected %0d, actual %0d",
				FRAME_BITS + 1, $sampled(since_rise) + 1);
			error_count++;
		end
	// 1 for a good word, 2 for a frame error
	report_kind: assert property (@(posedge clock) disable iff (reset)
		busy_prev && !tx_busy |-> {rx_frame_error, rx_valid} == (stop_high ? 2'b10 : 2'b01))
		else begin
			$error("FAILED frame report kind: expected %0h, actual %0h",
				$sampled(stop_high ? 2 : 1), $sampled({rx_frame_error, rx_valid}));
			error_count++;
		end
	loopback_word: assert property (@(posedge clock) disable iff (reset)
		rx_valid |-> rx_word == tx_bits)
		else begin
			$error("FAILED loopback word: expected %0h, actual %0h",
				$sampled(tx_bits), $sampled(rx_word));
			error_count++;
		end
	pattern_integrity: assert property (@(posedge clock) disable iff (reset)
		rx_valid |-> (rx_word & predict_mask) == (predicted & predict_mask))
		else begin
			$error("FAILED PRBS pattern: expected %0h, actual %0h",
				$sampled(predicted & predict_mask), $sampled(rx_word & predict_mask));
			error_count++;
		end

endmodule

/* test/serdes_link_tb.sv */
// loopback testbench for the serial test-pattern link
// loops serial_p back into serial_in with stop bit faults and pauses
// data_enable, the bound checker holds the assertions

`timescale 1ns/100ps

module serdes_link_tb import link_pkg::*; ();

	logic       clock;
	logic       reset;
	logic       data_enable;
	logic       serial_in;
	logic       link_ready;
	logic       serial_p;
	logic       serial_n;
	logic       tx_busy;
	link_word_t rx_word;
	logic       rx_valid;
	logic       rx_frame_error;
	// frames started, clocks into the current frame, reports seen
	int frames_started;
	int frame_clock;
	int good_words;
	int frame_errors;
	logic busy_seen;

	serdes_link_top DUT (.*);

	bind serdes_link_top serdes_link_checks checks (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_violation(input string what);
		$display("error: %s", what);
		stop_run();
	endtask

	initial begin
		wait (DUT.checks.error_count != 0);
		stop_run();
	end

	// loopback 1 ns after each edge, frames 7 and 28 get a stop bit of 1
	initial begin
		busy_seen = 1'b0;
		frame_clock = 0;
		frames_started = 0;
		good_words = 0;
		frame_errors = 0;
		forever begin
			@(posedge clock);
			#1;
			if (tx_busy && !busy_seen) begin
				frames_started++;
			end
			frame_clock = tx_busy ? frame_clock + 1 : 0;
			busy_seen = tx_busy;
			if (frame_clock == FRAME_BITS && (frames_started == 7 || frames_started == 28)) begin
				serial_in = 1'b1;
			end else begin
				serial_in = serial_p;
			end
			if (rx_valid) begin
				good_words++;
			end
			if (rx_frame_error) begin
				frame_errors++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		data_enable = 1'b0;
		serial_in = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		data_enable = 1'b1;
		// 20 frames, a pause of five word periods, then 20 more
		wait (frames_started == 20);
		data_enable = 1'b0;
		repeat (5 * WORD_PERIOD) @(posedge clock);
		#1;
		data_enable = 1'b1;
		wait (frames_started == 40);
		data_enable = 1'b0;
		wait (good_words + frame_errors == 40);
		repeat (WORD_PERIOD) @(posedge clock);
		// two of the 40 frames carry a broken stop bit
		if (good_words == 38 && frame_errors == 2) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("error: %0d words and %0d frame errors received, 38 and 2 expected",
				good_words, frame_errors);
			stop_run();
		end
	end

	// hold plus about 45 word periods of traffic, with room to spare
	initial begin
		#((RESET_HOLD + 60 * WORD_PERIOD) * 20 + 1000);
		report_violation("watchdog timeout before all frames were received");
	end

endmodule

/* vlog.f */
logic/link_pkg.sv
logic/prbs_pkg.sv
logic/power_on_reset.sv
logic/prbs_generator.sv
logic/word_scheduler.sv
logic/frame_serializer.sv
logic/frame_deserializer.sv
logic/serdes_link_top.sv
test/serdes_link_checks.sv
test/serdes_link_tb.sv
